/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_gb_mem_system
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
PASS_MSG ?= No errors
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* source/bus_decoder.sv */
/*
 * APB slave and memory map decoder.
 * Work RAM reads take one wait state, every other access completes at once.
 * Once bit 0 of the bootstrap register is set it stays set until reset.
 */
`timescale 1ns/10ps

module bus_decoder (
   input  logic clock,
   input  logic reset,
   input  logic psel,
   input  logic penable,
   input  logic pwrite,
   input  logic [gb_map_pkg::ADDR_W-1:0] paddr,
   input  logic [gb_map_pkg::DATA_W-1:0] pwdata,
   output logic [gb_map_pkg::DATA_W-1:0] prdata,
   output logic pready,
   output logic [gb_map_pkg::FLASH_ADDR_W-1:0] flash_addr,
   input  logic [gb_map_pkg::DATA_W-1:0] flash_data,
   mem_port_if.decoder ram_port,
   mem_port_if.decoder timer_port,
   mem_port_if.decoder irq_port
);
   import gb_map_pkg::*;
   import gb_io_pkg::*;

   logic access;
   logic [ADDR_W-1:0] boot_offset;
   logic [ADDR_W-1:0] wram_offset;
   logic [ADDR_W-1:0] timer_offset;
   logic in_boot;
   logic in_wram;
   logic in_timer;
   logic in_irq;
   logic in_boot_reg;
   logic wram_read;
   logic wram_wait;
   logic boot_done;

   assign access = psel & penable;

   // region decode, purely combinational from paddr
   assign boot_offset = paddr - BOOT_START;
   assign wram_offset = paddr - WRAM_START;
   assign timer_offset = paddr - TIMER_START;

   assign in_boot = boot_offset <= (BOOT_END - BOOT_START);
   assign in_wram = (paddr >= WRAM_START) && (paddr <= WRAM_END);
   assign in_timer = (paddr >= TIMER_START) && (paddr <= TIMER_END);
   assign in_irq = (paddr == IF_ADDR) || (paddr == IE_ADDR);
   assign in_boot_reg = paddr == BOOT_REG_ADDR;

   // target local buses
   assign ram_port.sel = access & in_wram;
   assign ram_port.write = pwrite;
   assign ram_port.addr = wram_offset[WRAM_ADDR_W-1:0];
   assign ram_port.wdata = pwdata;

   assign timer_port.sel = access & in_timer;
   assign timer_port.write = pwrite;
   assign timer_port.addr = timer_offset[TIMER_IDX_W-1:0];
   assign timer_port.wdata = pwdata;

   // 0 selects IF, 1 selects IE
   assign irq_port.sel = access & in_irq;
   assign irq_port.write = pwrite;
   assign irq_port.addr = paddr == IE_ADDR;
   assign irq_port.wdata = pwdata;

   assign flash_addr = boot_offset[FLASH_ADDR_W-1:0];

   // ram read data arrives one cycle after sel
   assign wram_read = in_wram & ~pwrite;
   assign pready = access & (~wram_read | wram_wait);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         wram_wait <= 1'b0;
         boot_done <= 1'b0;
      end else begin
         wram_wait <= access & wram_read & ~wram_wait;
         if (access && pwrite && in_boot_reg && pwdata[0]) begin
            boot_done <= 1'b1;
         end
      end
   end

   always_comb begin
      prdata = OPEN_BUS_DATA;
      if (in_boot) begin
         prdata = boot_done ? OPEN_BUS_DATA : flash_data;
      end else if (in_wram) begin
         prdata = ram_port.rdata;
      end else if (in_timer) begin
         prdata = timer_port.rdata;
      end else if (in_irq) begin
         prdata = irq_port.rdata;
      end else if (in_boot_reg) begin
         prdata = {{(DATA_W-1){1'b0}}, boot_done};
      end
   end

endmodule

/* source/div_timer.sv */
/*
 * Divider and programmable timer at FF04 to FF07.
 * The counter runs on every clock. Any DIV write clears all of it.
 * TIMA reloads from TMA one clock after it wraps, together with the request.
 */
`timescale 1ns/10ps

module div_timer (
   input  logic clock,
   input  logic reset,
   mem_port_if.target port,
   output logic timer_request
);
   import gb_map_pkg::*;
   import gb_io_pkg::*;

   logic [PRESCALE_W-1:0] counter;
   logic [DATA_W-1:0] tima;
   logic [DATA_W-1:0] tma;
   logic [TAC_SELECT_W:0] tac;
   logic reg_write;
   logic tap;
   logic tap_gated;
   logic tap_prev;
   logic tick;

   assign reg_write = port.sel & port.write;

   always_comb begin
      case (tac[TAC_SELECT_W-1:0])
         2'd0: tap = counter[TAP_SEL0];
         2'd1: tap = counter[TAP_SEL1];
         2'd2: tap = counter[TAP_SEL2];
         default: tap = counter[TAP_SEL3];
      endcase
   end

   // falling edge of the gated tap, so disabling the timer can also tick
   assign tap_gated = tac[TAC_ENABLE_BIT] & tap;
   assign tick = tap_prev & ~tap_gated;

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         counter <= '0;
         tima <= '0;
         tma <= '0;
         tac <= '0;
         tap_prev <= 1'b0;
         timer_request <= 1'b0;
      end else begin
         tap_prev <= tap_gated;
         timer_request <= tick && (tima == 8'hFF);

         if (reg_write && port.addr == DIV_IDX) begin
            counter <= '0;
         end else begin
            counter <= counter + 1'b1;
         end

         // pending reload first, a software write to TIMA overrides it
         if (timer_request) begin
            tima <= tma;
         end else if (tick) begin
            tima <= tima + 1'b1;
         end
         if (reg_write && port.addr == TIMA_IDX) begin
            tima <= port.wdata;
         end

         if (reg_write && port.addr == TMA_IDX) begin
            tma <= port.wdata;
         end
         if (reg_write && port.addr == TAC_IDX) begin
            tac <= port.wdata[TAC_SELECT_W:0];
         end
      end
   end

   always_comb begin
      case (port.addr)
         DIV_IDX: port.rdata = counter[DIV_LSB +: DATA_W];
         TIMA_IDX: port.rdata = tima;
         TMA_IDX: port.rdata = tma;
         default: port.rdata = {{(DATA_W-TAC_SELECT_W-1){1'b1}}, tac};
      endcase
   end

endmodule

/* source/gb_io_pkg.sv */
/*
 * Register layout of the divider, timer and interrupt blocks.
 * Tap bits assume the counter runs on the bus clock.
 */
package gb_io_pkg;

   localparam int unsigned TIMER_IDX_W = 2;
   localparam logic [TIMER_IDX_W-1:0] DIV_IDX = 2'd0;
   localparam logic [TIMER_IDX_W-1:0] TIMA_IDX = 2'd1;
   localparam logic [TIMER_IDX_W-1:0] TMA_IDX = 2'd2;
   localparam logic [TIMER_IDX_W-1:0] TAC_IDX = 2'd3;

   localparam int unsigned TAC_ENABLE_BIT = 2;
   localparam int unsigned TAC_SELECT_W = 2;

   localparam int unsigned PRESCALE_W = 16;
   localparam int unsigned DIV_LSB = 8;

   // counter bits watched for a falling edge, per TAC select value
   localparam int unsigned TAP_SEL0 = 9;
   localparam int unsigned TAP_SEL1 = 3;
   localparam int unsigned TAP_SEL2 = 5;
   localparam int unsigned TAP_SEL3 = 7;

   localparam int unsigned INT_W = 5;
   localparam int unsigned INT_VBLANK = 0;
   localparam int unsigned INT_LCDC = 1;
   localparam int unsigned INT_TIMER = 2;
   localparam int unsigned INT_SERIAL = 3;
   localparam int unsigned INT_JOYPAD = 4;

   localparam logic [2:0] IF_UNUSED_READ = 3'b111;

endpackage

/* source/gb_map_pkg.sv */
/*
 * Memory map of the console bus as seen from the APB port.
 * Only the boot window, work RAM, timer, interrupt and bootstrap
 * registers are mapped. Everything else reads as open bus.
 */
package gb_map_pkg;

   localparam int unsigned ADDR_W = 16;
   localparam int unsigned DATA_W = 8;

   // boot window, served from flash until the bootstrap bit is set
   localparam logic [ADDR_W-1:0] BOOT_START = 16'h0000;
   localparam logic [ADDR_W-1:0] BOOT_END = 16'h0103;
   localparam int unsigned FLASH_ADDR_W = 9;

   // 8 KiB work RAM
   localparam logic [ADDR_W-1:0] WRAM_START = 16'hC000;
   localparam logic [ADDR_W-1:0] WRAM_END = 16'hDFFF;
   localparam int unsigned WRAM_ADDR_W = 13;

   // io registers
   localparam logic [ADDR_W-1:0] TIMER_START = 16'hFF04;
   localparam logic [ADDR_W-1:0] TIMER_END = 16'hFF07;
   localparam logic [ADDR_W-1:0] IF_ADDR = 16'hFF0F;
   localparam logic [ADDR_W-1:0] IE_ADDR = 16'hFFFF;
   localparam logic [ADDR_W-1:0] BOOT_REG_ADDR = 16'hFF50;

   localparam logic [DATA_W-1:0] OPEN_BUS_DATA = 8'h00;

endpackage

/* source/gb_mem_system.sv */
/*
 * Top level of the memory system behind an APB slave port.
 * The boot window is read from an external asynchronous flash.
 * irq is the OR of all enabled pending interrupt flags.
 */
`timescale 1ns/10ps

module gb_mem_system (
   input  logic clock,
   input  logic reset,
   input  logic psel,
   input  logic penable,
   input  logic pwrite,
   input  logic [gb_map_pkg::ADDR_W-1:0] paddr,
   input  logic [gb_map_pkg::DATA_W-1:0] pwdata,
   output logic [gb_map_pkg::DATA_W-1:0] prdata,
   output logic pready,
   output logic [gb_map_pkg::FLASH_ADDR_W-1:0] flash_addr,
   input  logic [gb_map_pkg::DATA_W-1:0] flash_data,
   output logic irq
);
   import gb_map_pkg::*;
   import gb_io_pkg::*;

   logic timer_request;

   mem_port_if #(.ADDR_W_LOCAL(WRAM_ADDR_W)) ram_port ();
   mem_port_if #(.ADDR_W_LOCAL(TIMER_IDX_W)) timer_port ();
   mem_port_if #(.ADDR_W_LOCAL(1)) irq_port ();

   bus_decoder u_decoder (
      .clock(clock),
      .reset(reset),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .paddr(paddr),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .flash_addr(flash_addr),
      .flash_data(flash_data),
      .ram_port(ram_port.decoder),
      .timer_port(timer_port.decoder),
      .irq_port(irq_port.decoder)
   );

   work_ram u_work_ram (
      .clock(clock),
      .port(ram_port.target)
   );

   div_timer u_div_timer (
      .clock(clock),
      .reset(reset),
      .port(timer_port.target),
      .timer_request(timer_request)
   );

   interrupt_regs u_interrupt_regs (
      .clock(clock),
      .reset(reset),
      .port(irq_port.target),
      .timer_request(timer_request),
      .irq(irq)
   );

endmodule

/* source/interrupt_regs.sv */
/*
 * Interrupt flag and enable registers with a registered request.
 * Only the timer source has a hardware setter here.
 * A hardware set of the timer flag wins over a software write.
 */
`timescale 1ns/10ps

module interrupt_regs (
   input  logic clock,
   input  logic reset,
   mem_port_if.target port,
   input  logic timer_request,
   output logic irq
);
   import gb_io_pkg::*;

   logic [INT_W-1:0] if_reg;
   logic [INT_W-1:0] ie_reg;
   logic [INT_W-1:0] if_next;

   always_comb begin
      if_next = if_reg;
      if (port.sel && port.write && !port.addr[0]) begin
         if_next = port.wdata[INT_W-1:0];
      end
      if (timer_request) begin
         if_next[INT_TIMER] = 1'b1;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_reg <= '0;
         ie_reg <= '0;
         irq <= 1'b0;
      end else begin
         if_reg <= if_next;
         if (port.sel && port.write && port.addr[0]) begin
            ie_reg <= port.wdata[INT_W-1:0];
         end
         irq <= |(if_reg & ie_reg);
      end
   end

   assign port.rdata = port.addr[0] ? {3'b000, ie_reg} : {IF_UNUSED_READ, if_reg};

endmodule

/* source/mem_port_if.sv */
/*
 * Local bus between the decoder and one target.
 * sel is only high in the APB access phase of a hit on that target.
 */
`timescale 1ns/10ps

interface mem_port_if #(
   parameter int unsigned ADDR_W_LOCAL = 1
);
   import gb_map_pkg::*;

   logic sel;
   logic write;
   logic [ADDR_W_LOCAL-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W-1:0] rdata;

   modport decoder (output sel, output write, output addr, output wdata, input rdata);

   modport target (input sel, input write, input addr, input wdata, output rdata);

endinterface

/* source/work_ram.sv */
/*
 * 8 KiB single-port work RAM with a registered read.
 * Read data is valid in the cycle after sel rises.
 * A read during a write returns the old contents.
 */
`timescale 1ns/10ps

module work_ram (
   input  logic clock,
   mem_port_if.target port
);
   import gb_map_pkg::*;

   localparam int unsigned DEPTH = 2 ** WRAM_ADDR_W;

   logic [DATA_W-1:0] mem [0:DEPTH-1];

   always_ff @(posedge clock) begin
      if (port.sel) begin
         if (port.write) begin
            mem[port.addr] <= port.wdata;
         end
         port.rdata <= mem[port.addr];
      end
   end

endmodule

/* src.f */
source/gb_map_pkg.sv
source/gb_io_pkg.sv
source/mem_port_if.sv
source/bus_decoder.sv
source/work_ram.sv
source/div_timer.sv
source/interrupt_regs.sv
source/gb_mem_system.sv
tb/tb_gb_mem_system.sv

/* tb/tb_gb_mem_system.sv */
/*
 * Table-driven APB testbench for the console memory system.
 * The flash model is combinational. Its data is the low address byte XOR A5.
 * Stops at the first error.
 */
`timescale 1ns/10ps

module tb_gb_mem_system;
   import gb_map_pkg::*;

   localparam logic OP_READ = 1'b0;
   localparam logic OP_WRITE = 1'b1;
   localparam int PREADY_TIMEOUT = 20;
   localparam int IRQ_TIMEOUT = 200;
   localparam int RAM_TESTS = 6;
   localparam logic [ADDR_W-1:0] RAM_ADDRS [RAM_TESTS] =
      '{16'hC000, 16'hDFFF, 16'hC001, 16'hC7A3, 16'hD0F0, 16'hD9E6};

   logic clock;
   logic reset;
   logic psel;
   logic penable;
   logic pwrite;
   logic [ADDR_W-1:0] paddr;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic pready;
   logic [FLASH_ADDR_W-1:0] flash_addr;
   logic [DATA_W-1:0] flash_data;
   logic irq;

   // stimulus table
   logic op_q[$];
   logic [ADDR_W-1:0] addr_q[$];
   logic [DATA_W-1:0] wdata_q[$];
   logic [DATA_W-1:0] expect_q[$];
   string name_q[$];

   logic [31:0] lfsr_state = 32'hef86_32cd;

   gb_mem_system UUT (
      .clock(clock),
      .reset(reset),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .paddr(paddr),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .flash_addr(flash_addr),
      .flash_data(flash_data),
      .irq(irq)
   );

   function automatic logic [DATA_W-1:0] flash_pattern(input logic [ADDR_W-1:0] addr);
      return addr[7:0] ^ 8'hA5;
   endfunction

   assign flash_data = flash_pattern({{(ADDR_W-FLASH_ADDR_W){1'b0}}, flash_addr});

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // right-shifting Galois LFSR
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'h8020_0003;
      end
      return next;
   endfunction

   task automatic next_random_byte(output logic [DATA_W-1:0] value);
      for (int i = 0; i < DATA_W; i++) begin
         value[i] = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   task automatic stop_on_error();
      $display("Errors found");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         stop_on_error();
      end
   endtask

   task automatic enqueue_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                input string name);
      op_q.push_back(OP_WRITE);
      addr_q.push_back(addr);
      wdata_q.push_back(data);
      expect_q.push_back(8'h00);
      name_q.push_back(name);
   endtask

   task automatic expect_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input string name);
      op_q.push_back(OP_READ);
      addr_q.push_back(addr);
      wdata_q.push_back(8'h00);
      expect_q.push_back(data);
      name_q.push_back(name);
   endtask

   // one APB transfer that starts and returns 1 ns after a rising edge
   task automatic apb_access(input logic write_en, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
      int cycles;
      logic done;
      psel = 1'b1;
      penable = 1'b0;
      pwrite = write_en;
      paddr = addr;
      pwdata = wdata;
      @(posedge clock);
      #1;
      penable = 1'b1;
      cycles = 0;
      done = 1'b0;
      rdata = '0;
      while (!done && cycles < PREADY_TIMEOUT) begin
         @(negedge clock);
         cycles++;
         if (pready === 1'b1) begin
            done = 1'b1;
            rdata = prdata;
         end
      end
      if (!done) begin
         $display("pready stayed low for %0d cycles at address %h", PREADY_TIMEOUT, addr);
         stop_on_error();
      end
      @(posedge clock);
      #1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic wait_for_irq(input logic level, input string what);
      int cycles;
      cycles = 0;
      while (irq !== level && cycles < IRQ_TIMEOUT) begin
         @(negedge clock);
         cycles++;
      end
      if (irq !== level) begin
         $display("irq did not reach %0b within %0d cycles %s", level, IRQ_TIMEOUT, what);
         stop_on_error();
      end
      @(posedge clock);
      #1;
   endtask

   initial begin
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] ram_bytes [RAM_TESTS];
      int polls;

      reset = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      repeat (16) @(posedge clock);
      #1;
      reset = 1'b0;
      @(posedge clock);
      #1;

      // boot window is hidden for good once the bootstrap bit is set
      expect_read(16'h0000, flash_pattern(16'h0000), "boot 0000 visible");
      expect_read(16'h0042, flash_pattern(16'h0042), "boot 0042 visible");
      expect_read(16'h0103, flash_pattern(16'h0103), "boot 0103 visible");
      enqueue_write(16'hFF50, 8'h01, "set bootstrap");
      expect_read(16'h0000, 8'h00, "boot 0000 hidden");
      expect_read(16'h0042, 8'h00, "boot 0042 hidden");
      expect_read(16'h0103, 8'h00, "boot 0103 hidden");
      enqueue_write(16'hFF50, 8'h00, "clear bootstrap");
      expect_read(16'h0042, 8'h00, "boot stays hidden");

      for (int i = 0; i < RAM_TESTS; i++) begin
         next_random_byte(ram_bytes[i]);
         enqueue_write(RAM_ADDRS[i], ram_bytes[i], "wram write");
      end
      for (int i = 0; i < RAM_TESTS; i++) begin
         expect_read(RAM_ADDRS[i], ram_bytes[i], $sformatf("wram read %h", RAM_ADDRS[i]));
      end
      enqueue_write(16'hE000, 8'h3C, "write above wram");
      expect_read(16'hE000, 8'h00, "read above wram");

      enqueue_write(16'h8000, 8'h5A, "write 8000");
      enqueue_write(16'hFF10, 8'h5A, "write FF10");
      enqueue_write(16'hFF40, 8'h5A, "write FF40");
      expect_read(16'h8000, 8'h00, "unmapped 8000");
      expect_read(16'hFF10, 8'h00, "unmapped FF10");
      expect_read(16'hFF40, 8'h00, "unmapped FF40");

      enqueue_write(16'hFF06, 8'h3C, "write TMA");
      expect_read(16'hFF06, 8'h3C, "read TMA");
      enqueue_write(16'hFF07, 8'h05, "write TAC");
      expect_read(16'hFF07, 8'hFD, "read TAC");

      for (int i = 0; i < name_q.size(); i++) begin
         apb_access(op_q[i], addr_q[i], wdata_q[i], data);
         if (op_q[i] == OP_READ) begin
            check_value(name_q[i], expect_q[i], data);
         end
      end

      // let the divider run past 00 so that the clear is visible
      repeat (300) @(posedge clock);
      #1;
      apb_access(OP_WRITE, 16'hFF04, 8'h77, data);
      apb_access(OP_READ, 16'hFF04, 8'h00, data);
      check_value("read DIV after clear", 8'h00, data);

      // timer overflow raises the timer flag and irq
      apb_access(OP_WRITE, 16'hFF07, 8'h00, data);
      apb_access(OP_WRITE, 16'hFF0F, 8'h00, data);
      apb_access(OP_WRITE, 16'hFF05, 8'hFE, data);
      apb_access(OP_WRITE, 16'hFF06, 8'h80, data);
      apb_access(OP_WRITE, 16'hFF07, 8'h05, data);
      apb_access(OP_WRITE, 16'hFFFF, 8'h04, data);
      wait_for_irq(1'b1, "after TIMA overflow");
      apb_access(OP_READ, 16'hFF0F, 8'h00, data);
      check_value("IF after overflow", 8'hE4, data);
      apb_access(OP_READ, 16'hFF05, 8'h00, data);
      if (data < 8'h80) begin
         $display("Fail TIMA after overflow: expected at least 80, actual %h", data);
         stop_on_error();
      end
      apb_access(OP_WRITE, 16'hFF0F, 8'h00, data);
      wait_for_irq(1'b0, "after clearing IF");

      // masked overflow sets IF but leaves irq low
      apb_access(OP_WRITE, 16'hFFFF, 8'h00, data);
      apb_access(OP_WRITE, 16'hFF05, 8'hFE, data);
      polls = 0;
      data = 8'h00;
      while (data[2] !== 1'b1 && polls < IRQ_TIMEOUT / 2) begin
         apb_access(OP_READ, 16'hFF0F, 8'h00, data);
         check_value("irq while masked", 8'h00, {7'b0, irq});
         polls++;
      end
      check_value("IF after masked overflow", 8'hE4, data);
      repeat (2) @(posedge clock);
      #1;
      check_value("irq after masked overflow", 8'h00, {7'b0, irq});

      $display("No errors");
      $finish;
   end

endmodule
